//--- vlog.f
board_pkg.sv
read_addr_translate.sv
board_regs.sv
hub_mem.sv
reg_read_mux.sv
board_core.sv
board_checker.sv
tb_board_core.sv

//--- Makefile
# Verilator simulation of the board core

TOP = tb_board_core

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0 \
	    -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- tb_board_core.sv
// board core testbench

module tb_board_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_motors   = 4;
    localparam int num_encoders = 4;
    localparam int hub_depth    = 64;
    localparam int wdog_tick    = 4;
    localparam int num_ops      = 400;
    localparam int limit_cycles = num_ops * 4 + 200;   // longest run allowed

    logic                             sysclk;
    logic                             reset;
    logic [3:0]                       board_id;
    logic [board_pkg::addr_width-1:0] host_raddr;
    logic [board_pkg::addr_width-1:0] host_waddr;
    logic [board_pkg::quad_width-1:0] host_wdata;
    logic                             host_wen;
    logic                             host_blk_rt_rd;
    logic [board_pkg::quad_width-1:0] reg_rdata_ext;
    logic                             reg_rwait_ext;
    logic                             wdog_clear;
    logic [board_pkg::addr_width-1:0] reg_raddr;
    logic [board_pkg::addr_width-1:0] reg_waddr;
    logic [board_pkg::quad_width-1:0] reg_wdata;
    logic                             reg_wen;
    logic [board_pkg::quad_width-1:0] reg_rdata;
    logic                             reg_rwait;
    logic                             wdog_period_led;
    logic [2:0]                       wdog_period_status;
    logic                             wdog_timeout;
    logic                             run_done;        // stimulus finished
    int                               error_count;     // from the checker
    logic [31:0]                      lfsr_state;

    board_core #(
        .num_motors   (num_motors),
        .num_encoders (num_encoders),
        .hub_depth    (hub_depth),
        .wdog_tick    (wdog_tick)
    ) i_board_core (
        .sysclk (sysclk), .reset (reset), .board_id (board_id),
        .host_raddr (host_raddr), .host_waddr (host_waddr), .host_wdata (host_wdata),
        .host_wen (host_wen), .host_blk_rt_rd (host_blk_rt_rd),
        .reg_rdata_ext (reg_rdata_ext), .reg_rwait_ext (reg_rwait_ext),
        .reg_raddr (reg_raddr), .reg_waddr (reg_waddr), .reg_wdata (reg_wdata),
        .reg_wen (reg_wen), .reg_rdata (reg_rdata), .reg_rwait (reg_rwait),
        .wdog_clear (wdog_clear), .wdog_period_led (wdog_period_led),
        .wdog_period_status (wdog_period_status), .wdog_timeout (wdog_timeout)
    );

    board_checker #(
        .num_motors   (num_motors),
        .num_encoders (num_encoders),
        .hub_depth    (hub_depth),
        .wdog_tick    (wdog_tick)
    ) i_checker (
        .sysclk (sysclk), .reset (reset), .board_id (board_id),
        .host_raddr (host_raddr), .host_waddr (host_waddr), .host_wdata (host_wdata),
        .host_wen (host_wen), .host_blk_rt_rd (host_blk_rt_rd),
        .reg_rdata_ext (reg_rdata_ext), .reg_rwait_ext (reg_rwait_ext),
        .wdog_clear (wdog_clear), .reg_raddr (reg_raddr), .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata), .reg_wen (reg_wen), .reg_rdata (reg_rdata),
        .reg_rwait (reg_rwait), .wdog_period_led (wdog_period_led),
        .wdog_period_status (wdog_period_status), .wdog_timeout (wdog_timeout),
        .run_done (run_done), .error_count (error_count)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // ----------------------------------------------------------
    // random numbers
    // ----------------------------------------------------------

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit, newest bit ends up lowest
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        repeat (n) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // mostly channel 0 of main space, some hub, a few unmapped
    function automatic logic [15:0] pick_addr();
        logic [3:0] space;
        logic [3:0] upper;
        logic [3:0] chan;
        logic [3:0] offs;
        case (2'(take_bits(2)))
            2'd0, 2'd1: space = board_pkg::addr_main;
            2'd2:       space = board_pkg::addr_hub;
            default:    space = 4'(take_bits(4));
        endcase
        upper = 4'(take_bits(4));   // ignored by the decode
        if (space == board_pkg::addr_hub || take_bits(3) == 32'd0) chan = 4'(take_bits(4));
        else chan = 4'h0;
        if (take_bits(2) == 32'd0) offs = 4'(take_bits(4));
        else offs = 4'(take_bits(2));  // registers 0..3
        return {space, upper, chan, offs};
    endfunction

    // short periods so idle gaps can trip the flag
    function automatic logic [31:0] pick_period();
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        if (sel == 3'd0) return 32'd0;          // watchdog off
        if (sel < 3'd3) return take_bits(4 * (1 + int'(take_bits(2))));  // width sets range
        return 32'd1 + take_bits(2);
    endfunction

    // ----------------------------------------------------------
    // bus operations
    // ----------------------------------------------------------

    // inputs move 5 ns after the edge, strobes last one cycle
    task automatic next_cycle();
        @(posedge sysclk);
        #5;
        host_wen   = 1'b0;
        wdog_clear = 1'b0;
    endtask

    task automatic do_write(input logic [15:0] addr);
        host_waddr = addr;
        if (addr[15:12] == board_pkg::addr_main && addr[7:4] == 4'h0
            && addr[3:0] == board_pkg::reg_wdog_period) host_wdata = pick_period();
        else host_wdata = take_bits(32);
        host_wen = 1'b1;
        next_cycle();
    endtask

    task automatic do_read();
        host_blk_rt_rd = (take_bits(3) == 32'd0);
        if (host_blk_rt_rd) host_raddr = {8'(take_bits(8)), 2'b00, 6'(take_bits(6))};
        else host_raddr = pick_addr();
        reg_rdata_ext = (take_bits(3) == 32'd0) ? take_bits(32) : 32'd0;  // usually idle
        reg_rwait_ext = (take_bits(3) == 32'd0);
        repeat (2) next_cycle();    // address held for the hub wait state
        host_blk_rt_rd = 1'b0;
        reg_rdata_ext  = '0;
        reg_rwait_ext  = 1'b0;
    endtask

    task automatic run_op();
        int gap;
        wdog_clear = (take_bits(4) == 32'd0);
        if (take_bits(1) == 32'd1) do_write(pick_addr());
        else do_read();
        if (take_bits(4) == 32'd0) gap = 6 + int'(take_bits(4));  // long idle stretch
        else gap = int'(take_bits(1));
        repeat (gap) next_cycle();
    endtask

    initial begin
        lfsr_state     = 32'h58f4_9a85;
        reset          = 1'b1;
        board_id       = 4'(take_bits(4));
        host_raddr     = '0;
        host_waddr     = '0;
        host_wdata     = '0;
        host_wen       = 1'b0;
        host_blk_rt_rd = 1'b0;
        reg_rdata_ext  = '0;
        reg_rwait_ext  = 1'b0;
        wdog_clear     = 1'b0;
        run_done       = 1'b0;
        repeat (8) @(posedge sysclk);
        #5;
        reset = 1'b0;
        repeat (num_ops) run_op();
        repeat (4) next_cycle();
        run_done = 1'b1;
        #1;     // checker prints its counts first
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run length bound
    initial begin
        repeat (limit_cycles) @(posedge sysclk);
        $display("timeout: stimulus did not finish within %0d cycles", limit_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- board_checker.sv
// register bus reference model and checks

module board_checker #(
    parameter int num_motors   = 4,
    parameter int num_encoders = 4,
    parameter int hub_depth    = 64,
    parameter int wdog_tick    = 4
) (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [3:0]  board_id,
    input  logic [15:0] host_raddr,
    input  logic [15:0] host_waddr,
    input  logic [31:0] host_wdata,
    input  logic        host_wen,
    input  logic        host_blk_rt_rd,
    input  logic [31:0] reg_rdata_ext,
    input  logic        reg_rwait_ext,
    input  logic        wdog_clear,
    input  logic [15:0] reg_raddr,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic [31:0] reg_rdata,
    input  logic        reg_rwait,
    input  logic        wdog_period_led,
    input  logic [2:0]  wdog_period_status,
    input  logic        wdog_timeout,
    input  logic        run_done,
    output int          error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int hub_idx_w = $clog2(hub_depth);

    int          check_count;
    logic [31:0] m_scratch;
    logic [15:0] m_period;
    logic [31:0] m_count;       // idle cycles seen by the watchdog
    logic [31:0] m_limit;
    logic        m_timeout;
    logic [31:0] m_hub [hub_depth];
    logic [31:0] m_hub_rd;      // hub data registered last cycle
    logic [31:0] next_count;
    logic        main_wr;
    logic [15:0] exp_raddr;
    logic [31:0] exp_rdata;
    logic        exp_rwait;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // ----------------------------------------------------------
    // expected values
    // ----------------------------------------------------------

    function automatic logic [15:0] chan_addr(input int chan, input int offs);
        return {board_pkg::addr_main, 4'h0, chan[3:0], offs[3:0]};
    endfunction

    // block read layout: 4 main quads, 2 per motor, 5 per encoder
    function automatic logic [15:0] map_raddr(input logic [15:0] a, input logic blk);
        int q;
        int k;
        int mot_end;
        int enc_end;
        q       = int'(a[7:0]);
        mot_end = 4 + 2 * num_motors;
        enc_end = mot_end + 5 * num_encoders;
        if (!blk || q >= enc_end) return a;
        if (q < 4) return chan_addr(0, q);
        if (q < mot_end) begin
            k = q - 4;
            return chan_addr(k / 2 + 1, k % 2);
        end
        k = q - mot_end;
        return chan_addr(k / 5 + 1, 2 + k % 5);
    endfunction

    function automatic logic [31:0] main_read(input logic [3:0] offs);
        logic [31:0] d;
        d = '0;
        case (offs)
            board_pkg::reg_status: begin
                d[3:0] = board_id;
                d[8]   = m_timeout;
                d[9]   = (m_period != 16'd0);   // led bit
            end
            board_pkg::reg_version:     d = 32'h0000_0107;
            board_pkg::reg_scratch:     d = m_scratch;
            board_pkg::reg_wdog_period: d = {16'h0000, m_period};
            default:                    d = '0;
        endcase
        return d;
    endfunction

    function automatic logic [2:0] period_range(input logic [15:0] p);
        if (p == 16'd0) return 3'd0;
        if (p < 16'd16) return 3'd1;
        if (p < 16'd256) return 3'd2;
        if (p < 16'd4096) return 3'd3;
        return 3'd4;
    endfunction

    function automatic logic [hub_idx_w-1:0] hub_index(input logic [15:0] a);
        return hub_idx_w'(int'(a) % hub_depth);     // wraps modulo depth
    endfunction

    // ----------------------------------------------------------
    // compare mid cycle, then step the model past the next edge
    // ----------------------------------------------------------

    always @(negedge sysclk) begin
        check_value("reg_waddr", 32'(host_waddr), 32'(reg_waddr));
        check_value("reg_wdata", host_wdata, reg_wdata);
        check_value("reg_wen", 32'(host_wen), 32'(reg_wen));
        exp_raddr = map_raddr(host_raddr, host_blk_rt_rd);
        if (!reset) begin
            check_value("reg_raddr", 32'(exp_raddr), 32'(reg_raddr));
            if (exp_raddr[15:12] == board_pkg::addr_hub) begin
                exp_rdata = m_hub_rd;
                exp_rwait = 1'b1;
            end else if (exp_raddr[15:12] == board_pkg::addr_main && exp_raddr[7:4] == 4'h0) begin
                exp_rdata = main_read(exp_raddr[3:0]);
                exp_rwait = 1'b0;
            end else begin
                exp_rdata = '0;     // unmapped
                exp_rwait = 1'b0;
            end
            check_value("reg_rdata", exp_rdata | reg_rdata_ext, reg_rdata);
            check_value("reg_rwait", 32'(exp_rwait | reg_rwait_ext), 32'(reg_rwait));
            check_value("wdog_timeout", 32'(m_timeout), 32'(wdog_timeout));
            check_value("wdog_period_led", 32'(m_period != 16'd0), 32'(wdog_period_led));
            check_value("wdog_period_status", 32'(period_range(m_period)),
                        32'(wdog_period_status));
        end
        m_limit = 32'(m_period) * 32'(wdog_tick);
        if (reset) begin
            m_scratch = '0;
            m_period  = '0;
            m_count   = '0;
            m_timeout = 1'b0;
            m_hub_rd  = '0;
            m_hub     = '{default: '0};
        end else begin
            main_wr = host_wen && host_waddr[15:12] == board_pkg::addr_main
                      && host_waddr[7:4] == 4'h0;
            // any write restarts the count, it holds once at the limit
            if (host_wen || m_period == 16'd0) next_count = '0;
            else if (m_count < m_limit) next_count = m_count + 32'd1;
            else next_count = m_count;
            if (wdog_clear || (main_wr && host_waddr[3:0] == board_pkg::reg_wdog_period))
                m_timeout = 1'b0;
            else if (m_period != 16'd0 && next_count == m_limit && m_count != m_limit)
                m_timeout = 1'b1;   // limit reached this edge
            m_count  = next_count;
            m_hub_rd = m_hub[hub_index(exp_raddr)];    // old contents on a same-edge write
            if (host_wen && host_waddr[15:12] == board_pkg::addr_hub)
                m_hub[hub_index(host_waddr)] = host_wdata;
            if (main_wr && host_waddr[3:0] == board_pkg::reg_scratch) m_scratch = host_wdata;
            if (main_wr && host_waddr[3:0] == board_pkg::reg_wdog_period)
                m_period = host_wdata[15:0];
        end
    end

    always @(posedge run_done) begin
        $display("%0d errors in %0d checks", error_count, check_count);
    end

endmodule

//--- board_core.sv
// motor board register bus core

module board_core #(
    parameter int num_motors   = 4,
    parameter int num_encoders = 4,
    parameter int hub_depth    = 64,
    parameter int wdog_tick    = 50000     // cycles per watchdog period unit
) (
    // global clock and reset
    input  logic                             sysclk,
    input  logic                             reset,

    input  logic [3:0]                       board_id,        // rotary switch

    // host link
    input  logic [board_pkg::addr_width-1:0] host_raddr,
    input  logic [board_pkg::addr_width-1:0] host_waddr,
    input  logic [board_pkg::quad_width-1:0] host_wdata,
    input  logic                             host_wen,
    input  logic                             host_blk_rt_rd,  // real-time block read

    // external board read return
    input  logic [board_pkg::quad_width-1:0] reg_rdata_ext,
    input  logic                             reg_rwait_ext,

    // register bus
    output logic [board_pkg::addr_width-1:0] reg_raddr,
    output logic [board_pkg::addr_width-1:0] reg_waddr,
    output logic [board_pkg::quad_width-1:0] reg_wdata,
    output logic                             reg_wen,
    output logic [board_pkg::quad_width-1:0] reg_rdata,
    output logic                             reg_rwait,

    // watchdog
    input  logic                             wdog_clear,
    output logic                             wdog_period_led,     // LED shows status
    output logic [2:0]                       wdog_period_status,
    output logic                             wdog_timeout
);

    logic [board_pkg::quad_width-1:0] main_rdata;  // channel 0 registers
    logic [board_pkg::quad_width-1:0] hub_rdata;   // hub memory

    // ----------------------------------------------------------
    // write bus, host is the only master
    // ----------------------------------------------------------

    assign reg_wen   = host_wen;
    assign reg_waddr = host_waddr;
    assign reg_wdata = host_wdata;

    // ----------------------------------------------------------
    // read address translation
    // ----------------------------------------------------------

    read_addr_translate #(
        .num_motors   (num_motors),
        .num_encoders (num_encoders)
    ) i_read_addr (
        .raddr_in  (host_raddr),
        .blk_rt_rd (host_blk_rt_rd),
        .raddr_out (reg_raddr)
    );

    // ----------------------------------------------------------
    // board registers and watchdog
    // ----------------------------------------------------------

    board_regs #(
        .wdog_tick (wdog_tick)
    ) i_chan0 (
        .sysclk             (sysclk),
        .reset              (reset),
        .board_id           (board_id),
        .reg_raddr          (reg_raddr),
        .reg_waddr          (reg_waddr),
        .reg_wdata          (reg_wdata),
        .reg_wen            (reg_wen),
        .wdog_clear         (wdog_clear),
        .reg_rdata          (main_rdata),
        .wdog_period_led    (wdog_period_led),
        .wdog_period_status (wdog_period_status),
        .wdog_timeout       (wdog_timeout)
    );

    // ----------------------------------------------------------
    // hub memory and read routing
    // ----------------------------------------------------------

    hub_mem #(
        .hub_depth (hub_depth)
    ) i_hub (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .reg_rdata (hub_rdata)
    );

    reg_read_mux i_read_mux (
        .reg_raddr     (reg_raddr),
        .hub_rdata     (hub_rdata),
        .main_rdata    (main_rdata),
        .reg_rdata_ext (reg_rdata_ext),
        .reg_rwait_ext (reg_rwait_ext),
        .reg_rdata     (reg_rdata),
        .reg_rwait     (reg_rwait)
    );

endmodule

//--- reg_read_mux.sv
// read data routing by address space

module reg_read_mux (
    input  logic [board_pkg::addr_width-1:0] reg_raddr,
    input  logic [board_pkg::quad_width-1:0] hub_rdata,      // registered hub data
    input  logic [board_pkg::quad_width-1:0] main_rdata,     // board registers
    input  logic [board_pkg::quad_width-1:0] reg_rdata_ext,  // external board data
    input  logic                             reg_rwait_ext,  // external wait state
    output logic [board_pkg::quad_width-1:0] reg_rdata,
    output logic                             reg_rwait
);

    logic [3:0]                       space;
    logic                             is_main;   // channel 0 of main space
    logic [board_pkg::quad_width-1:0] sel_rdata;
    logic                             sel_rwait;

    assign space   = reg_raddr[15:12];
    assign is_main = (space == board_pkg::addr_main) && (reg_raddr[7:4] == 4'h0);

    // ----------------------------------------------------------
    // source select
    // ----------------------------------------------------------

    // reg_rwait low means data valid in the same cycle as reg_raddr
    // reg_rwait high means valid one sysclk later
    always_comb begin
        sel_rdata = '0;     // unmapped spaces read 0
        sel_rwait = 1'b0;
        if (space == board_pkg::addr_hub) begin
            sel_rdata = hub_rdata;
            sel_rwait = 1'b1;   // memory read takes a wait state
        end else if (is_main) begin
            sel_rdata = main_rdata;
        end
    end

    // ----------------------------------------------------------
    // merge with the external board
    // ----------------------------------------------------------

    // external board drives 0 outside its own addresses
    assign reg_rdata = sel_rdata | reg_rdata_ext;
    assign reg_rwait = sel_rwait | reg_rwait_ext;

    // an X wait flag would stall or corrupt the host read
    always_comb begin
        if (!$isunknown(reg_raddr)) begin
            assert final (!$isunknown(reg_rwait))
                else $error("reg_rwait unknown for address %h", reg_raddr);
        end
    end

endmodule

//--- hub_mem.sv
// hub quadlet memory

module hub_mem #(
    parameter int hub_depth = 64    // quadlets, power of two
) (
    input  logic                             sysclk,
    input  logic                             reset,
    input  logic [board_pkg::addr_width-1:0] reg_raddr,
    input  logic [board_pkg::addr_width-1:0] reg_waddr,
    input  logic [board_pkg::quad_width-1:0] reg_wdata,
    input  logic                             reg_wen,
    output logic [board_pkg::quad_width-1:0] reg_rdata  // one cycle after reg_raddr
);

    localparam int idx_w = $clog2(hub_depth);

    logic [board_pkg::quad_width-1:0] mem [hub_depth];
    logic                             hub_wr;
    logic [idx_w-1:0]                 widx;     // write quad index
    logic [idx_w-1:0]                 ridx;     // read quad index

    // ----------------------------------------------------------
    // address decode
    // ----------------------------------------------------------

    assign hub_wr = reg_wen && (reg_waddr[15:12] == board_pkg::addr_hub);

    // low address bits wrap modulo the depth
    assign widx = reg_waddr[idx_w-1:0];
    assign ridx = reg_raddr[idx_w-1:0];

    // ----------------------------------------------------------
    // storage and registered read
    // ----------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < hub_depth; i++) begin
                mem[i] <= '0;   // hub starts empty
            end
            reg_rdata <= '0;
        end else begin
            if (hub_wr) begin
                mem[widx] <= reg_wdata;
            end
            // read every cycle, the mux only uses it in hub space
            // a write to the same quad shows up one cycle later
            reg_rdata <= mem[ridx];
        end
    end

    // index slicing needs a power-of-two depth of at least 2
    if ((hub_depth < 2) || ((hub_depth & (hub_depth - 1)) != 0)) begin : g_depth_check
        $error("hub_depth %0d is not a power of two", hub_depth);
    end

endmodule

//--- board_regs.sv
// board registers and watchdog

module board_regs #(
    parameter int wdog_tick = 50000     // sysclk cycles per period unit
) (
    input  logic                             sysclk,
    input  logic                             reset,
    input  logic [3:0]                       board_id,   // rotary switch
    input  logic [board_pkg::addr_width-1:0] reg_raddr,
    input  logic [board_pkg::addr_width-1:0] reg_waddr,
    input  logic [board_pkg::quad_width-1:0] reg_wdata,
    input  logic                             reg_wen,
    input  logic                             wdog_clear,  // drop the timeout flag
    output logic [board_pkg::quad_width-1:0] reg_rdata,
    output logic                             wdog_period_led,
    output logic [2:0]                       wdog_period_status,
    output logic                             wdog_timeout
);

    localparam int pw = board_pkg::wdog_period_width;
    localparam int cw = board_pkg::wdog_count_width;

    logic [board_pkg::quad_width-1:0] scratch;
    logic [pw-1:0]                    wdog_period;  // 0 turns the watchdog off
    logic [cw-1:0]                    wdog_count;   // cycles since last write
    logic [cw-1:0]                    wdog_limit;   // count that trips the flag
    logic                             main_wr;
    logic                             period_wr;
    logic                             wdog_hit;

    // writes to channel 0 of the main space only
    assign main_wr   = reg_wen && (reg_waddr[15:12] == board_pkg::addr_main)
                       && (reg_waddr[7:4] == 4'h0);
    assign period_wr = main_wr && (reg_waddr[3:0] == board_pkg::reg_wdog_period);

    // ----------------------------------------------------------
    // writable registers
    // ----------------------------------------------------------

    always_ff @(posedge sysclk) begin
        if (reset) begin
            scratch     <= '0;
            wdog_period <= '0;
        end else if (main_wr) begin
            case (reg_waddr[3:0])
                board_pkg::reg_scratch:     scratch     <= reg_wdata;
                board_pkg::reg_wdog_period: wdog_period <= reg_wdata[pw-1:0];  // low half
                default: ;                  // read-only or unmapped
            endcase
        end
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------

    assign wdog_limit = cw'(wdog_period) * cw'(wdog_tick);

    // count stops at the limit so the flag sets once per idle stretch
    always_ff @(posedge sysclk) begin
        if (reset || reg_wen || (wdog_period == '0)) begin
            wdog_count <= '0;   // any bus write restarts it
        end else if (wdog_count != wdog_limit) begin
            wdog_count <= wdog_count + 1'b1;
        end
    end

    // next edge brings the count to the limit
    assign wdog_hit = !reg_wen && (wdog_count == wdog_limit - 1'b1);

    always_ff @(posedge sysclk) begin
        if (reset || wdog_clear || period_wr) begin
            wdog_timeout <= 1'b0;
        end else if (wdog_hit) begin
            wdog_timeout <= 1'b1;
        end
    end

    assign wdog_period_led = (wdog_period != '0);

    // coarse period range for the LED display
    always_comb begin
        if (wdog_period == '0)            wdog_period_status = 3'd0;  // off
        else if (wdog_period < pw'(16))   wdog_period_status = 3'd1;
        else if (wdog_period < pw'(256))  wdog_period_status = 3'd2;
        else if (wdog_period < pw'(4096)) wdog_period_status = 3'd3;
        else                              wdog_period_status = 3'd4;
    end

    // ----------------------------------------------------------
    // read decode, space check is done in the read mux
    // ----------------------------------------------------------

    always_comb begin
        reg_rdata = '0;     // unknown offsets read 0
        case (reg_raddr[3:0])
            board_pkg::reg_status: begin
                reg_rdata[3:0]                         = board_id;
                reg_rdata[board_pkg::status_timeout_bit] = wdog_timeout;
                reg_rdata[board_pkg::status_led_bit]     = wdog_period_led;
            end
            board_pkg::reg_version:     reg_rdata = board_pkg::fw_version;
            board_pkg::reg_scratch:     reg_rdata = scratch;
            board_pkg::reg_wdog_period: reg_rdata = {{(board_pkg::quad_width - pw){1'b0}},
                                                     wdog_period};
            default: ;
        endcase
    end

    // timeout must only come from a running watchdog
    assert property (@(posedge sysclk) disable iff (reset)
                     $rose(wdog_timeout) |-> wdog_period_led)
        else $error("wdog_timeout rose with the watchdog period off");

endmodule

//--- read_addr_translate.sv
// real-time block read address translation

module read_addr_translate #(
    parameter int num_motors   = 4,
    parameter int num_encoders = 4
) (
    input  logic [board_pkg::addr_width-1:0] raddr_in,   // host read address
    input  logic                             blk_rt_rd,  // block read in progress
    output logic [board_pkg::addr_width-1:0] raddr_out   // address seen by the bus
);

    // first quad index of each section in the block
    localparam int mot_first = board_pkg::blk_main_quads;
    localparam int enc_first = mot_first + board_pkg::mot_quads * num_motors;
    localparam int blk_quads = enc_first + board_pkg::enc_quads * num_encoders;

    logic [7:0] quad_idx;   // q, index within the block
    logic [7:0] mot_idx;    // q relative to the motor section
    logic [7:0] enc_idx;    // q relative to the encoder section
    logic [7:0] mot_chan;
    logic [7:0] mot_offs;
    logic [7:0] enc_chan;
    logic [7:0] enc_offs;

    assign quad_idx = raddr_in[7:0];
    assign mot_idx  = quad_idx - 8'(mot_first);
    assign enc_idx  = quad_idx - 8'(enc_first);

    // channels count from 1, channel 0 is the board itself
    assign mot_chan = mot_idx / 8'(board_pkg::mot_quads) + 8'd1;
    assign mot_offs = mot_idx % 8'(board_pkg::mot_quads);
    assign enc_chan = enc_idx / 8'(board_pkg::enc_quads) + 8'd1;
    assign enc_offs = enc_idx % 8'(board_pkg::enc_quads) + 8'(board_pkg::enc_first_offset);

    // ----------------------------------------------------------
    // block map
    // ----------------------------------------------------------

    always_comb begin
        raddr_out = raddr_in;   // plain reads pass through
        if (blk_rt_rd) begin
            if (int'(quad_idx) < mot_first) begin
                // main register q of channel 0
                raddr_out = {board_pkg::addr_main, 8'h00, quad_idx[3:0]};
            end else if (int'(quad_idx) < enc_first) begin
                raddr_out = {board_pkg::addr_main, 4'h0, mot_chan[3:0], mot_offs[3:0]};
            end else if (int'(quad_idx) < blk_quads) begin
                raddr_out = {board_pkg::addr_main, 4'h0, enc_chan[3:0], enc_offs[3:0]};
            end
            // indices past the block keep the host address
        end
    end

    // quad index is only 8 bits wide
    if (blk_quads > board_pkg::blk_max_quads) begin : g_blk_len_check
        $error("block read of %0d quads exceeds the quad index range", blk_quads);
    end

endmodule

//--- board_pkg.sv
// board register bus definitions

package board_pkg;

    // ----------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------

    localparam int quad_width = 32;         // one data quadlet
    localparam int addr_width = 16;         // register bus address

    // ----------------------------------------------------------
    // address spaces, held in addr[15:12]
    // ----------------------------------------------------------

    localparam logic [3:0] addr_main = 4'h0;    // board registers and channels
    localparam logic [3:0] addr_hub  = 4'h2;    // hub quadlet memory

    // ----------------------------------------------------------
    // board register offsets, addr[3:0] of channel 0
    // ----------------------------------------------------------

    localparam logic [3:0] reg_status      = 4'h0;  // id, watchdog flags
    localparam logic [3:0] reg_version     = 4'h1;  // firmware version
    localparam logic [3:0] reg_scratch     = 4'h2;  // free read/write word
    localparam logic [3:0] reg_wdog_period = 4'h3;  // watchdog period

    // status word bit positions
    // board id sits in bits 3..0
    localparam int status_timeout_bit = 8;
    localparam int status_led_bit     = 9;

    // firmware release reported by reg_version
    localparam logic [31:0] fw_version = 32'h0000_0107;

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------

    localparam int wdog_period_width = 16;  // stored period bits
    localparam int wdog_count_width  = 32;  // holds period * tick

    // ----------------------------------------------------------
    // real-time block read layout
    // ----------------------------------------------------------

    // quad 0..3 are main registers
    localparam int blk_main_quads = 4;

    // then per-motor quads, offsets 0 and 1 of each channel
    localparam int mot_quads = 2;

    // then per-encoder quads starting at channel offset 2
    localparam int enc_quads        = 5;
    localparam int enc_first_offset = 2;

    // largest block the 8-bit quad index can reach
    localparam int blk_max_quads = 256;

endpackage
